// ==== motor_cmd_writer.f ====
src/motor_cmd_pkg.sv
src/motor_cmd_sequencer.sv
src/axi_addr_stage.sv
src/axi_data_stage.sv
src/axi_resp_stage.sv
src/motor_cmd_writer.sv
test/tb_motor_cmd_writer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the motor command writer testbench with Verilator, then check the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_motor_cmd_writer -f motor_cmd_writer.f -o tb_sim \
	&& ./obj_dir/tb_sim 2>&1 | tee sim.log \
	|| echo "Compile or simulation run failed"
grep -qx "TEST PASS" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== src/axi_addr_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_addr_stage (
	input  logic                     sys_clk,
	input  logic                     sys_rst,
	input  logic                     issue,
	input  logic                     abort,
	input  motor_cmd_pkg::axi_id_t   id,
	input  logic                     awready,
	output motor_cmd_pkg::axi_id_t   awid,
	output motor_cmd_pkg::axi_addr_t awaddr,
	output logic                     awvalid,
	output logic                     aw_done
);

	// Address accepted this cycle
	assign aw_done = awvalid && awready && !abort;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			awvalid <= 1'b0;
		end else if (abort || aw_done) begin
			awvalid <= 1'b0;
		end else if (issue) begin
			awvalid <= 1'b1;
		end
	end

	// Payload held from issue until the handshake
	always_ff @(posedge sys_clk) begin
		if (issue) begin
			awid   <= id;
			awaddr <= motor_cmd_pkg::MOTOR_CMD_ADDR;
		end
	end

	a_aw_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		awvalid && !awready && !abort |=> awvalid && $stable(awid) && $stable(awaddr));

endmodule

`default_nettype wire

// ==== src/axi_data_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_data_stage (
	input  logic                     sys_clk,
	input  logic                     sys_rst,
	input  logic                     aw_done,
	input  logic                     abort,
	input  motor_cmd_pkg::cmd_num_t  cmd_num,
	input  logic                     wready,
	output motor_cmd_pkg::axi_data_t wdata,
	output logic                     wvalid,
	output logic                     w_done
);

	motor_cmd_pkg::axi_data_t cmd_word;

	// ************************************************************
	// Command word
	// ************************************************************
	// enable | positive | 6 zero bits | command number | 16 zero bits
	assign cmd_word = {
		motor_cmd_pkg::MOTOR_ENABLE_CODE,
		motor_cmd_pkg::MOTOR_POSITIVE_CODE,
		6'b0,
		cmd_num,
		16'b0
	};

	assign w_done = wvalid && wready && !abort;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wvalid <= 1'b0;
		end else if (abort || w_done) begin
			wvalid <= 1'b0;
		end else if (aw_done) begin
			wvalid <= 1'b1;
		end
	end

	// Captured once per write
	always_ff @(posedge sys_clk) begin
		if (aw_done) begin
			wdata <= cmd_word;
		end
	end

	a_w_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wvalid && !wready && !abort |=> wvalid && $stable(wdata));

endmodule

`default_nettype wire

// ==== src/axi_resp_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_resp_stage (
	input  logic                    sys_clk,
	input  logic                    sys_rst,
	input  logic                    w_done,
	input  logic                    abort,
	input  logic                    bvalid,
	output logic                    bready,
	output logic                    b_done,
	output motor_cmd_pkg::cmd_num_t cmd_num
);

	// ************************************************************
	// Write response
	// ************************************************************
	// Response taken unless the watchdog fires in the same cycle
	assign b_done = bready && bvalid && !abort;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			bready <= 1'b0;
		end else if (abort || b_done) begin
			bready <= 1'b0;
		end else if (w_done) begin
			bready <= 1'b1;
		end
	end

	// ************************************************************
	// Command number
	// ************************************************************
	// Advances only on a finished write and holds through a timeout
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cmd_num <= motor_cmd_pkg::CMD_NUM_INIT;
		end else if (b_done) begin
			cmd_num <= cmd_num + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/motor_cmd_pkg.sv ====
`default_nettype none

package motor_cmd_pkg;

	// ************************************************************
	// Bus and counter widths
	// ************************************************************
	localparam int WATCHDOG_WIDTH = 12;
	localparam int WATCHDOG_LIMIT = 2 ** WATCHDOG_WIDTH;

	typedef logic [3:0]              axi_id_t;
	typedef logic [31:0]             axi_addr_t;
	typedef logic [63:0]             axi_data_t;
	typedef logic [9:0]              cmd_num_t;
	typedef logic [WATCHDOG_WIDTH:0] wdog_cnt_t;

	// ************************************************************
	// Motor command register and its codes
	// ************************************************************
	localparam axi_addr_t MOTOR_CMD_ADDR = 32'hE000_0000;

	// Top two 16-bit fields of the command word
	localparam logic [15:0] MOTOR_ENABLE_CODE   = 16'hEAEA;
	localparam logic [15:0] MOTOR_POSITIVE_CODE = 16'h1EAF;

	// Command number after reset
	localparam cmd_num_t CMD_NUM_INIT = 10'h078;

	// Sequencer FSM
	typedef enum logic [1:0] {
		IDLE,
		BUSY,
		ACK
	} seq_state_t;

endpackage

`default_nettype wire

// ==== src/motor_cmd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_cmd_sequencer (
	input  logic                   sys_clk,
	input  logic                   sys_rst,
	input  logic                   start_req,
	input  logic                   b_done,
	output logic                   start_ack,
	output logic                   timed_out,
	output logic                   issue,
	output logic                   abort,
	output motor_cmd_pkg::axi_id_t id
);

	motor_cmd_pkg::seq_state_t state;
	motor_cmd_pkg::wdog_cnt_t  wdog_cnt;

	// New write only from IDLE
	assign issue = (state == motor_cmd_pkg::IDLE) && start_req;

	// Watchdog expires WATCHDOG_LIMIT cycles after issue
	assign abort = (state == motor_cmd_pkg::BUSY) &&
		(wdog_cnt == motor_cmd_pkg::wdog_cnt_t'(motor_cmd_pkg::WATCHDOG_LIMIT - 1));

	assign start_ack = (state == motor_cmd_pkg::ACK);

	// ************************************************************
	// Request FSM
	// ************************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state     <= motor_cmd_pkg::IDLE;
			timed_out <= 1'b0;
		end else begin
			case (state)
				motor_cmd_pkg::IDLE: begin
					if (start_req) begin
						state <= motor_cmd_pkg::BUSY;
					end
				end
				motor_cmd_pkg::BUSY: begin
					// Watchdog wins over a late response
					if (abort) begin
						state     <= motor_cmd_pkg::ACK;
						timed_out <= 1'b1;
					end else if (b_done) begin
						state     <= motor_cmd_pkg::ACK;
						timed_out <= 1'b0;
					end
				end
				motor_cmd_pkg::ACK: begin
					// Four-phase close once the requester lets go
					if (!start_req) begin
						state     <= motor_cmd_pkg::IDLE;
						timed_out <= 1'b0;
					end
				end
				default: begin
					state     <= motor_cmd_pkg::IDLE;
					timed_out <= 1'b0;
				end
			endcase
		end
	end

	// ************************************************************
	// Transaction ID and watchdog
	// ************************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			id       <= '0;
			wdog_cnt <= '0;
		end else if (issue) begin
			id       <= id + 1'b1;
			wdog_cnt <= '0;
		end else if (state == motor_cmd_pkg::BUSY) begin
			wdog_cnt <= wdog_cnt + 1'b1;
		end
	end

	// Requester keeps start_req up while its write is open
	a_req_held: assert property (@(posedge sys_clk) disable iff (sys_rst)
		(state == motor_cmd_pkg::BUSY) |-> start_req);

	// A response only ever closes a write this FSM started
	a_resp_busy: assert property (@(posedge sys_clk) disable iff (sys_rst)
		b_done |-> (state == motor_cmd_pkg::BUSY));

endmodule

`default_nettype wire

// ==== src/motor_cmd_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_cmd_writer (
	input  logic                     sys_clk,
	input  logic                     sys_rst,
	input  logic                     start_req,
	output logic                     start_ack,
	output logic                     timed_out,
	output motor_cmd_pkg::axi_id_t   awid,
	output motor_cmd_pkg::axi_addr_t awaddr,
	output logic                     awvalid,
	input  logic                     awready,
	output motor_cmd_pkg::axi_data_t wdata,
	output logic                     wvalid,
	input  logic                     wready,
	output logic                     bready,
	input  logic                     bvalid
);

	logic                    issue;
	logic                    abort;
	motor_cmd_pkg::axi_id_t  id;
	logic                    aw_done;
	logic                    w_done;
	logic                    b_done;
	motor_cmd_pkg::cmd_num_t cmd_num;

	// ************************************************************
	// Intake and watchdog
	// ************************************************************
	motor_cmd_sequencer seq_i (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.start_req (start_req),
		.b_done    (b_done),
		.start_ack (start_ack),
		.timed_out (timed_out),
		.issue     (issue),
		.abort     (abort),
		.id        (id)
	);

	// ************************************************************
	// AXI write channels, one stage each
	// ************************************************************
	axi_addr_stage addr_i (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.issue   (issue),
		.abort   (abort),
		.id      (id),
		.awready (awready),
		.awid    (awid),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.aw_done (aw_done)
	);

	axi_data_stage data_i (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.aw_done (aw_done),
		.abort   (abort),
		.cmd_num (cmd_num),
		.wready  (wready),
		.wdata   (wdata),
		.wvalid  (wvalid),
		.w_done  (w_done)
	);

	axi_resp_stage resp_i (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.w_done  (w_done),
		.abort   (abort),
		.bvalid  (bvalid),
		.bready  (bready),
		.b_done  (b_done),
		.cmd_num (cmd_num)
	);

endmodule

`default_nettype wire

// ==== test/tb_motor_cmd_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_motor_cmd_writer;

	localparam int NUM_REQUESTS = 24;
	localparam int ACK_LIMIT    = 2 * motor_cmd_pkg::WATCHDOG_LIMIT;
	localparam int RUN_CYCLES   = NUM_REQUESTS * 40 + 2 * motor_cmd_pkg::WATCHDOG_LIMIT;
	localparam logic [31:0] SEED = 32'h33d799e2;

	logic sys_clk = 1'b0;
	logic sys_rst = 1'b1;
	logic start_req = 1'b0;
	logic awready = 1'b0;
	logic wready = 1'b0;
	logic bvalid = 1'b0;
	logic start_ack;
	logic timed_out;
	logic awvalid;
	logic wvalid;
	logic bready;
	motor_cmd_pkg::axi_id_t   awid;
	motor_cmd_pkg::axi_addr_t awaddr;
	motor_cmd_pkg::axi_data_t wdata;

	// Slave model wait counters sit at -1 when not armed
	logic hold_resp = 1'b0;
	int aw_wait = -1;
	int w_wait = -1;
	int b_wait = -1;

	// Transfer counts and error counts
	int aw_cnt = 0;
	int w_cnt = 0;
	int b_cnt = 0;
	int req_total = 0;
	int resp_total = 0;
	int mismatch_cnt = 0;
	int fail_cnt = 0;

	motor_cmd_writer dut_i (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .start_req(start_req), .start_ack(start_ack),
		.timed_out(timed_out), .awid(awid), .awaddr(awaddr), .awvalid(awvalid),
		.awready(awready), .wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bready(bready), .bvalid(bvalid)
	);

	initial begin
		forever #5 sys_clk = ~sys_clk;
	end

	// ************************************************************
	// AXI slave model
	// ************************************************************
	always @(posedge sys_clk) begin
		if (sys_rst || !awvalid || awready) begin
			awready <= 1'b0;
			aw_wait <= -1;
		end else if (aw_wait < 0) aw_wait <= $urandom_range(5, 0);
		else if (aw_wait == 0) awready <= 1'b1;
		else aw_wait <= aw_wait - 1;
	end

	always @(posedge sys_clk) begin
		if (sys_rst || !wvalid || wready) begin
			wready <= 1'b0;
			w_wait <= -1;
		end else if (w_wait < 0) w_wait <= $urandom_range(5, 0);
		else if (w_wait == 0) wready <= 1'b1;
		else w_wait <= w_wait - 1;
	end

	// Response armed by the data handshake unless held back
	always @(posedge sys_clk) begin
		if (sys_rst || (bvalid && bready)) begin
			bvalid <= 1'b0;
			b_wait <= -1;
		end else if (wvalid && wready && !hold_resp) b_wait <= $urandom_range(5, 0);
		else if (b_wait == 0) begin
			bvalid <= 1'b1;
			b_wait <= -1;
		end else if (b_wait > 0) b_wait <= b_wait - 1;
	end

	// Expected write from the number of issued and completed writes
	function automatic void expected_write(input int issued, input int completed,
		output motor_cmd_pkg::axi_id_t id, output motor_cmd_pkg::axi_addr_t addr,
		output motor_cmd_pkg::axi_data_t data);
		motor_cmd_pkg::cmd_num_t num;
		num  = motor_cmd_pkg::CMD_NUM_INIT + motor_cmd_pkg::cmd_num_t'(completed);
		id   = motor_cmd_pkg::axi_id_t'(issued);
		addr = motor_cmd_pkg::MOTOR_CMD_ADDR;
		data = (motor_cmd_pkg::axi_data_t'(motor_cmd_pkg::MOTOR_ENABLE_CODE) << 48)
			| (motor_cmd_pkg::axi_data_t'(motor_cmd_pkg::MOTOR_POSITIVE_CODE) << 32)
			| (motor_cmd_pkg::axi_data_t'(num) << 16);
	endfunction

	// ************************************************************
	// Monitor and checker
	// ************************************************************
	always @(posedge sys_clk) begin : monitor
		motor_cmd_pkg::axi_id_t   exp_id;
		motor_cmd_pkg::axi_addr_t exp_addr;
		motor_cmd_pkg::axi_data_t exp_data;
		logic aw_hold;
		logic w_hold;
		logic resp_seen;
		logic last_awvalid;
		logic last_req;
		logic last_ack;
		motor_cmd_pkg::axi_id_t   last_awid;
		motor_cmd_pkg::axi_addr_t last_awaddr;
		motor_cmd_pkg::axi_data_t last_wdata;
		if (!sys_rst) begin
			expected_write(aw_cnt, b_cnt, exp_id, exp_addr, exp_data);
			if (aw_hold && (!awvalid || awid !== last_awid || awaddr !== last_awaddr)) begin
				$display("Address channel changed before awready at %0t", $time);
				fail_cnt++;
			end
			if (w_hold && (!wvalid || wdata !== last_wdata)) begin
				$display("Data channel changed before wready at %0t", $time);
				fail_cnt++;
			end
			if (awvalid && awready) begin
				if (awid !== exp_id) begin
					$display("MISMATCH awid: got %h, expected %h", awid, exp_id);
					mismatch_cnt++;
				end
				if (awaddr !== exp_addr) begin
					$display("MISMATCH awaddr: got %h, expected %h", awaddr, exp_addr);
					mismatch_cnt++;
				end
				aw_cnt++;
			end
			if (wvalid && wready) begin
				if (wdata !== exp_data) begin
					$display("MISMATCH wdata: got %h, expected %h", wdata, exp_data);
					mismatch_cnt++;
				end
				w_cnt++;
			end
			if (bvalid && bready) begin
				b_cnt++;
				resp_seen = 1'b1;
			end
			if (awvalid && !last_awvalid) begin
				if (!last_req) begin
					$display("awvalid rose with no request pending at %0t", $time);
					fail_cnt++;
				end
				resp_seen = 1'b0;
			end
			if (start_ack && !last_ack && !timed_out && !resp_seen) begin
				$display("start_ack rose before the write response at %0t", $time);
				fail_cnt++;
			end
			if (!start_ack && last_ack && last_req) begin
				$display("start_ack fell while start_req was still high at %0t", $time);
				fail_cnt++;
			end
		end
		aw_hold = !sys_rst && awvalid && !awready;
		w_hold = !sys_rst && wvalid && !wready;
		last_awvalid = awvalid;
		last_req = start_req;
		last_ack = start_ack;
		last_awid = awid;
		last_awaddr = awaddr;
		last_wdata = wdata;
	end

	// One full four-phase request
	task automatic run_request(input logic expect_timeout);
		int cycles;
		start_req <= 1'b1;
		cycles = 0;
		do begin
			@(posedge sys_clk);
			cycles++;
		end while (!start_ack && cycles < ACK_LIMIT);
		if (!start_ack) begin
			$display("No start_ack within %0d cycles of the request", ACK_LIMIT);
			fail_cnt++;
		end else if (timed_out !== expect_timeout) begin
			$display("MISMATCH timed_out: got %h, expected %h", timed_out, expect_timeout);
			mismatch_cnt++;
		end
		if (expect_timeout && bready !== 1'b0) begin
			$display("bready still high after the watchdog fired");
			fail_cnt++;
		end
		start_req <= 1'b0;
		do begin
			@(posedge sys_clk);
			cycles++;
		end while (start_ack && cycles < 2 * ACK_LIMIT);
		if (start_ack) begin
			$display("start_ack stayed high after start_req fell");
			fail_cnt++;
		end
		req_total++;
		if (!expect_timeout) resp_total++;
		if (aw_cnt != req_total || w_cnt != req_total || b_cnt != resp_total) begin
			$display("Transfer count off after request %0d: aw %0d, w %0d, b %0d",
				req_total, aw_cnt, w_cnt, b_cnt);
			fail_cnt++;
		end
	endtask

	initial begin
		void'($urandom(SEED));
		repeat (4) @(posedge sys_clk);
		sys_rst <= 1'b0;
		@(posedge sys_clk);
		if (awvalid !== 1'b0 || wvalid !== 1'b0 || bready !== 1'b0 ||
			start_ack !== 1'b0 || timed_out !== 1'b0) begin
			$display("Outputs not idle after reset");
			fail_cnt++;
		end
		for (int i = 0; i < NUM_REQUESTS; i++) begin
			// One request with the response withheld
			hold_resp <= (i == 20);
			run_request(i == 20);
			repeat ($urandom_range(3, 0)) @(posedge sys_clk);
		end
		$display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		repeat (RUN_CYCLES) @(posedge sys_clk);
		$display("Run stopped after %0d cycles without finishing", RUN_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
